//--- ddr2pe_pkg.sv
package ddr2pe_pkg;

    // ddr side
    localparam int DDR_W       = 64;
    localparam int DDR_ADDR_W  = 32;
    localparam int BURST_W     = 4;
    localparam int BURST_LEN   = 4;
    localparam int BEAT_BYTES  = 8;
    localparam int BURST_BYTES = BURST_LEN * BEAT_BYTES;

    // pe array and its buffers
    localparam int PE_NUM     = 32;
    localparam int PE_IDX_W   = 5;
    localparam int BUF_DEPTH  = 256;
    localparam int BUF_ADDR_W = $clog2(BUF_DEPTH);
    localparam int IDX_W      = 16;

    // instruction word
    localparam int INST_W = 64;

    localparam int OP_W     = 4;
    localparam int BUF_ID_W = 6;
    localparam int BURSTS_W = 8;
    // holds up to 255 bursts of BURST_LEN beats
    localparam int BEATS_W  = 10;

    localparam int OP_LSB       = 60;
    localparam int BUF_ID_LSB   = 54;
    localparam int PE_LSB       = 49;
    localparam int BURSTS_LSB   = 41;
    // bit 40 reserved
    localparam int BUF_ADDR_LSB = 32;
    localparam int ADDR_LSB     = 0;

    typedef enum logic [OP_W-1:0] {
        OP_NOP       = 4'd0,
        OP_LOAD_DBUF = 4'd1,
        OP_LOAD_IBUF = 4'd2
    } ins_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_WAIT
    } loader_state_t;

endpackage

//--- ins_decode.sv
`timescale 1ns/1ps

module ins_decode
    import ddr2pe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ins_valid,
    input  logic [INST_W-1:0]     ins,
    output logic                  ins_ready,
    input  logic                  rx_done_pulse,
    output logic                  gen_start,
    output logic [DDR_ADDR_W-1:0] gen_addr,
    output logic [BURSTS_W-1:0]   gen_bursts,
    output logic                  wr_start,
    output ins_op_t               wr_op,
    output logic [PE_IDX_W-1:0]   wr_pe,
    output logic [BUF_ADDR_W-1:0] wr_base,
    output logic [BUF_ID_W-1:0]   wr_buf_id,
    output logic [BEATS_W-1:0]    wr_beats
);

    loader_state_t state;

    ins_op_t               ins_op;
    logic [BUF_ID_W-1:0]   ins_buf_id;
    logic [PE_IDX_W-1:0]   ins_pe;
    logic [BURSTS_W-1:0]   ins_bursts;
    logic [BUF_ADDR_W-1:0] ins_base;
    logic [DDR_ADDR_W-1:0] ins_addr;
    logic [BEATS_W-1:0]    ins_beats;
    logic                  accept;
    logic                  is_load;

    // field slicing
    assign ins_op     = ins_op_t'(ins[OP_LSB +: OP_W]);
    assign ins_buf_id = ins[BUF_ID_LSB +: BUF_ID_W];
    assign ins_pe     = ins[PE_LSB +: PE_IDX_W];
    assign ins_bursts = ins[BURSTS_LSB +: BURSTS_W];
    assign ins_base   = ins[BUF_ADDR_LSB +: BUF_ADDR_W];
    assign ins_addr   = ins[ADDR_LSB +: DDR_ADDR_W];
    assign ins_beats  = BEATS_W'(ins_bursts) * BEATS_W'(BURST_LEN);

    assign ins_ready = (state == ST_IDLE);
    assign accept    = ins_valid && ins_ready;

    // nop, unknown opcodes and empty loads are dropped
    assign is_load = ((ins_op == OP_LOAD_DBUF) || (ins_op == OP_LOAD_IBUF))
                     && (ins_bursts != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            gen_start <= 1'b0;
            wr_start  <= 1'b0;
        end else begin
            gen_start <= 1'b0;
            wr_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept && is_load) begin
                        state     <= ST_BUSY;
                        gen_start <= 1'b1;
                        wr_start  <= 1'b1;
                    end else if (accept) begin
                        state <= ST_WAIT;
                    end
                end
                ST_BUSY: begin
                    if (rx_done_pulse) begin
                        state <= ST_IDLE;
                    end
                end
                ST_WAIT: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            gen_addr   <= ins_addr;
            gen_bursts <= ins_bursts;
            wr_op      <= ins_op;
            wr_pe      <= ins_pe;
            wr_base    <= ins_base;
            wr_buf_id  <= ins_buf_id;
            wr_beats   <= ins_beats;
        end
    end

    // both starts fire together, and only right after an accepted instruction
    a_start_after_accept: assert property (@(posedge clk) disable iff (rst)
        (gen_start || wr_start) |-> ($past(accept) && (gen_start == wr_start)));

endmodule

//--- ddr_addr_gen.sv
`timescale 1ns/1ps

module ddr_addr_gen
    import ddr2pe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  gen_start,
    input  logic [DDR_ADDR_W-1:0] gen_addr,
    input  logic [BURSTS_W-1:0]   gen_bursts,
    output logic [DDR_ADDR_W-1:0] ddr1_addr,
    output logic [BURST_W-1:0]    ddr1_size,
    output logic                  ddr1_addr_valid,
    input  logic                  ddr1_addr_ready
);

    loader_state_t       state;
    logic [BURSTS_W-1:0] bursts_left;
    logic                addr_fire;

    assign ddr1_addr_valid = (state == ST_BUSY);
    assign ddr1_size       = BURST_W'(BURST_LEN);
    assign addr_fire       = ddr1_addr_valid && ddr1_addr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            bursts_left <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (gen_start && (gen_bursts != '0)) begin
                        state       <= ST_BUSY;
                        bursts_left <= gen_bursts;
                    end
                end
                ST_BUSY: begin
                    if (addr_fire) begin
                        bursts_left <= bursts_left - 1'b1;
                        // last burst taken
                        if (bursts_left == BURSTS_W'(1)) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // burst address walks forward one burst per accepted request
    always_ff @(posedge clk) begin
        if (gen_start) begin
            ddr1_addr <= gen_addr;
        end else if (addr_fire) begin
            ddr1_addr <= ddr1_addr + DDR_ADDR_W'(BURST_BYTES);
        end
    end

    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (ddr1_addr_valid && !ddr1_addr_ready) |=>
            (ddr1_addr_valid && $stable(ddr1_addr) && $stable(ddr1_size)));

endmodule

//--- buf_writer.sv
`timescale 1ns/1ps

module buf_writer
    import ddr2pe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_start,
    input  ins_op_t               wr_op,
    input  logic [PE_IDX_W-1:0]   wr_pe,
    input  logic [BUF_ADDR_W-1:0] wr_base,
    input  logic [BUF_ID_W-1:0]   wr_buf_id,
    input  logic [BEATS_W-1:0]    wr_beats,
    input  logic [DDR_W-1:0]      ddr1_data,
    input  logic                  ddr1_valid,
    output logic                  ddr1_ready,
    output logic [BUF_ADDR_W-1:0] dbuf_wr_addr,
    output logic [DDR_W-1:0]      dbuf_wr_data,
    output logic [PE_NUM-1:0]     dbuf_wr_en,
    output logic [BUF_ADDR_W-1:0] idx_wr_addr,
    output logic [2*IDX_W-1:0]    idx_wr_data,
    output logic [PE_NUM-1:0]     idx_wr_en,
    output logic                  rx_done_pulse,
    output logic [BUF_ID_W-1:0]   rx_done_buf_id,
    output ins_op_t               rx_done_opcode
);

    loader_state_t         state;
    logic [BEATS_W-1:0]    beats_left;
    logic [BUF_ADDR_W-1:0] buf_addr;
    ins_op_t               op_q;
    logic [PE_IDX_W-1:0]   pe_q;
    logic [BUF_ID_W-1:0]   buf_id_q;
    logic [PE_NUM-1:0]     pe_onehot;
    logic                  beat;
    logic                  last_beat;

    assign ddr1_ready = (state == ST_BUSY);
    assign beat       = ddr1_valid && ddr1_ready;
    assign last_beat  = beat && (beats_left == BEATS_W'(1));
    assign pe_onehot  = PE_NUM'(1) << pe_q;

    // done info is held from the start of the load
    assign rx_done_buf_id = buf_id_q;
    assign rx_done_opcode = op_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            beats_left    <= '0;
            dbuf_wr_en    <= '0;
            idx_wr_en     <= '0;
            rx_done_pulse <= 1'b0;
        end else begin
            dbuf_wr_en    <= '0;
            idx_wr_en     <= '0;
            rx_done_pulse <= 1'b0;
            if (state == ST_IDLE && wr_start) begin
                state      <= ST_BUSY;
                beats_left <= wr_beats;
            end else if (beat) begin
                beats_left <= beats_left - 1'b1;
                if (op_q == OP_LOAD_DBUF) begin
                    dbuf_wr_en <= pe_onehot;
                end else begin
                    idx_wr_en <= pe_onehot;
                end
                // done goes out with the last write
                if (last_beat) begin
                    state         <= ST_IDLE;
                    rx_done_pulse <= 1'b1;
                end
            end
        end
    end

    // instruction info and write payload
    always_ff @(posedge clk) begin
        if (wr_start) begin
            op_q     <= wr_op;
            pe_q     <= wr_pe;
            buf_id_q <= wr_buf_id;
            buf_addr <= wr_base;
        end else if (beat) begin
            buf_addr <= buf_addr + 1'b1;
        end
        if (beat) begin
            dbuf_wr_addr <= buf_addr;
            dbuf_wr_data <= ddr1_data;
            idx_wr_addr  <= buf_addr;
            // two 16-bit indices per word
            idx_wr_data  <= ddr1_data[2*IDX_W-1:0];
        end
    end

    a_one_buffer: assert property (@(posedge clk) disable iff (rst)
        !((|dbuf_wr_en) && (|idx_wr_en)));

    a_one_pe: assert property (@(posedge clk) disable iff (rst)
        $onehot0(dbuf_wr_en) && $onehot0(idx_wr_en));

endmodule

//--- ddr2pe.sv
`timescale 1ns/1ps

module ddr2pe
    import ddr2pe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ins_valid,
    output logic                  ins_ready,
    input  logic [INST_W-1:0]     ins,
    output logic                  rx_done_pulse,
    output logic [BUF_ID_W-1:0]   rx_done_buf_id,
    output ins_op_t               rx_done_opcode,
    input  logic [DDR_W-1:0]      ddr1_data,
    input  logic                  ddr1_valid,
    output logic                  ddr1_ready,
    output logic [DDR_ADDR_W-1:0] ddr1_addr,
    output logic [BURST_W-1:0]    ddr1_size,
    output logic                  ddr1_addr_valid,
    input  logic                  ddr1_addr_ready,
    output logic [BUF_ADDR_W-1:0] dbuf_wr_addr,
    output logic [DDR_W-1:0]      dbuf_wr_data,
    output logic [PE_NUM-1:0]     dbuf_wr_en,
    output logic [BUF_ADDR_W-1:0] idx_wr_addr,
    output logic [2*IDX_W-1:0]    idx_wr_data,
    output logic [PE_NUM-1:0]     idx_wr_en
);

    // decode to address generator
    logic                  gen_start;
    logic [DDR_ADDR_W-1:0] gen_addr;
    logic [BURSTS_W-1:0]   gen_bursts;

    // decode to buffer writer
    logic                  wr_start;
    ins_op_t               wr_op;
    logic [PE_IDX_W-1:0]   wr_pe;
    logic [BUF_ADDR_W-1:0] wr_base;
    logic [BUF_ID_W-1:0]   wr_buf_id;
    logic [BEATS_W-1:0]    wr_beats;

    // all wires carry the port names of the submodules
    ins_decode u_ins_decode (.*);

    ddr_addr_gen u_ddr_addr_gen (.*);

    buf_writer u_buf_writer (.*);

endmodule

//--- tb_checks.svh
// expected events are filled per instruction and consumed by the monitor
logic [DDR_ADDR_W-1:0] exp_addr_q[$];
logic [BUF_ADDR_W-1:0] exp_wr_addr_q[$];
logic [DDR_W-1:0]      exp_wr_data_q[$];
logic [BUF_ID_W-1:0]   exp_done_id_q[$];
ins_op_t               exp_done_op_q[$];
ins_op_t               exp_op = OP_NOP;
logic [PE_NUM-1:0]     exp_en = '0;

int    errors = 0;
int    checks = 0;
string test_name = "reset";

// a beat at byte address a carries {a, ~a}
task automatic model_instruction(input logic [INST_W-1:0] word, output logic is_load);
    logic [OP_W-1:0]       raw_op;
    logic [DDR_ADDR_W-1:0] start;
    logic [DDR_ADDR_W-1:0] beat_addr;
    logic [BUF_ADDR_W-1:0] base;
    logic [PE_IDX_W-1:0]   pe;
    int                    n_bursts;
    raw_op   = word[OP_LSB +: OP_W];
    start    = word[ADDR_LSB +: DDR_ADDR_W];
    base     = word[BUF_ADDR_LSB +: BUF_ADDR_W];
    n_bursts = int'(word[BURSTS_LSB +: BURSTS_W]);
    is_load  = ((raw_op == OP_LOAD_DBUF) || (raw_op == OP_LOAD_IBUF)) && (n_bursts != 0);
    if (is_load) begin
        exp_op     = ins_op_t'(raw_op);
        pe         = word[PE_LSB +: PE_IDX_W];
        exp_en     = '0;
        exp_en[pe] = 1'b1;
        for (int j = 0; j < n_bursts; j++) begin
            exp_addr_q.push_back(start + DDR_ADDR_W'(j * BURST_BYTES));
        end
        for (int k = 0; k < n_bursts * BURST_LEN; k++) begin
            beat_addr = start + DDR_ADDR_W'(k * BEAT_BYTES);
            exp_wr_addr_q.push_back(base + BUF_ADDR_W'(k));
            exp_wr_data_q.push_back({beat_addr, ~beat_addr});
        end
        exp_done_id_q.push_back(word[BUF_ID_LSB +: BUF_ID_W]);
        exp_done_op_q.push_back(exp_op);
    end
endtask

task automatic report_failure(input string what);
    errors++;
    $display("%s failed: %s", test_name, what);
endtask

task automatic check_idle();
    logic [5:0] act;
    act = {ins_ready, ddr1_addr_valid, ddr1_ready, |dbuf_wr_en, |idx_wr_en, rx_done_pulse};
    checks++;
    if (act !== 6'b100000) begin
        errors++;
        $display("Error %s expected %b actual %b", test_name, 6'b100000, act);
    end
endtask

task automatic check_addr(input logic [DDR_ADDR_W-1:0] exp_addr, act_addr,
                          input logic [BURST_W-1:0] exp_size, act_size);
    checks++;
    if (act_addr !== exp_addr || act_size !== exp_size) begin
        errors++;
        $display("Error %s expected %h/%0d actual %h/%0d", test_name, exp_addr, exp_size,
                 act_addr, act_size);
    end
endtask

task automatic check_dbuf(input logic [BUF_ADDR_W-1:0] exp_addr, act_addr,
                          input logic [DDR_W-1:0] exp_data, act_data,
                          input logic [PE_NUM-1:0] exp_en, act_en);
    checks++;
    if (act_addr !== exp_addr || act_data !== exp_data || act_en !== exp_en) begin
        errors++;
        $display("Error %s expected %h %h %h actual %h %h %h", test_name, exp_addr, exp_data,
                 exp_en, act_addr, act_data, act_en);
    end
endtask

task automatic check_ibuf(input logic [BUF_ADDR_W-1:0] exp_addr, act_addr,
                          input logic [2*IDX_W-1:0] exp_data, act_data,
                          input logic [PE_NUM-1:0] exp_en, act_en);
    checks++;
    if (act_addr !== exp_addr || act_data !== exp_data || act_en !== exp_en) begin
        errors++;
        $display("Error %s expected %h %h %h actual %h %h %h", test_name, exp_addr, exp_data,
                 exp_en, act_addr, act_data, act_en);
    end
endtask

task automatic check_done(input logic [BUF_ID_W-1:0] exp_id, act_id,
                          input ins_op_t exp_opc, act_opc);
    checks++;
    if (act_id !== exp_id || act_opc !== exp_opc) begin
        errors++;
        $display("Error %s expected id %0d op %0d actual id %0d op %0d", test_name, exp_id,
                 exp_opc, act_id, act_opc);
    end
endtask

//--- tb_ddr2pe.sv
`timescale 1ns/1ps

module tb_ddr2pe
    import ddr2pe_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int DRIVE_DELAY     = 2;
    localparam int NUM_INS         = 40;
    localparam int MAX_BURSTS      = 6;
    localparam int WATCHDOG_CYCLES = NUM_INS * (MAX_BURSTS * BURST_LEN * 8 + 20);

    logic                  clk;
    logic                  rst;
    logic                  ins_valid;
    logic                  ins_ready;
    logic [INST_W-1:0]     ins;
    logic                  rx_done_pulse;
    logic [BUF_ID_W-1:0]   rx_done_buf_id;
    ins_op_t               rx_done_opcode;
    logic [DDR_W-1:0]      ddr1_data;
    logic                  ddr1_valid;
    logic                  ddr1_ready;
    logic [DDR_ADDR_W-1:0] ddr1_addr;
    logic [BURST_W-1:0]    ddr1_size;
    logic                  ddr1_addr_valid;
    logic                  ddr1_addr_ready;
    logic [BUF_ADDR_W-1:0] dbuf_wr_addr;
    logic [DDR_W-1:0]      dbuf_wr_data;
    logic [PE_NUM-1:0]     dbuf_wr_en;
    logic [BUF_ADDR_W-1:0] idx_wr_addr;
    logic [2*IDX_W-1:0]    idx_wr_data;
    logic [PE_NUM-1:0]     idx_wr_en;

    integer                seed = 32'h207dc7fc;
    logic [INST_W-1:0]     ins_list[NUM_INS];
    logic [DDR_ADDR_W-1:0] beat_q[$];
    logic [DDR_W-1:0]      beat_word;
    logic                  waiting_done = 1'b0;
    logic                  held_valid = 1'b0;
    logic [DDR_ADDR_W-1:0] held_addr;
    logic [BURST_W-1:0]    held_size;

    `include "tb_checks.svh"

    ddr2pe DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic build_instructions();
        int              sel;
        logic [OP_W-1:0] op;
        for (int i = 0; i < NUM_INS; i++) begin
            sel = {$random(seed)} % 10;
            // mostly loads with a few nops and unknown codes
            if (sel < 4) op = OP_LOAD_DBUF;
            else if (sel < 8) op = OP_LOAD_IBUF;
            else if (sel == 8) op = OP_NOP;
            else op = OP_W'(3 + {$random(seed)} % 13);
            ins_list[i] = '0;
            ins_list[i][OP_LSB +: OP_W] = op;
            ins_list[i][BUF_ID_LSB +: BUF_ID_W] = BUF_ID_W'($random(seed));
            ins_list[i][PE_LSB +: PE_IDX_W] = PE_IDX_W'($random(seed));
            ins_list[i][BURSTS_LSB +: BURSTS_W] = BURSTS_W'({$random(seed)} % (MAX_BURSTS + 1));
            ins_list[i][BUF_ADDR_LSB +: BUF_ADDR_W] = BUF_ADDR_W'($random(seed));
            ins_list[i][ADDR_LSB +: DDR_ADDR_W] = DDR_ADDR_W'($random(seed) & ~(BURST_BYTES - 1));
        end
    endtask

    // ddr model answers accepted bursts in order with random stalls
    task automatic drive_ddr();
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            ddr1_addr_ready = ($random(seed) % 4) != 0;
            if (beat_q.size() != 0 && ($random(seed) % 3) != 0) begin
                ddr1_valid = 1'b1;
                ddr1_data  = {beat_q[0], ~beat_q[0]};
            end else begin
                ddr1_valid = 1'b0;
            end
        end
    endtask

    // outputs are stable at the falling edge and match what the next rising edge samples
    task automatic monitor_outputs();
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (ins_ready && waiting_done) report_failure("ready before the done pulse");
                if (held_valid) begin
                    if (!ddr1_addr_valid) report_failure("address valid dropped while stalled");
                    check_addr(held_addr, ddr1_addr, held_size, ddr1_size);
                end
                held_valid = ddr1_addr_valid && !ddr1_addr_ready;
                held_addr  = ddr1_addr;
                held_size  = ddr1_size;
                if (ddr1_addr_valid && ddr1_addr_ready) begin
                    if (exp_addr_q.size() == 0) begin
                        report_failure("unexpected DDR address");
                    end else begin
                        check_addr(exp_addr_q.pop_front(), ddr1_addr, BURST_W'(BURST_LEN),
                                   ddr1_size);
                    end
                    for (int b = 0; b < BURST_LEN; b++) begin
                        beat_q.push_back(ddr1_addr + DDR_ADDR_W'(b * BEAT_BYTES));
                    end
                end
                if (ddr1_valid && ddr1_ready) void'(beat_q.pop_front());
                if (|dbuf_wr_en) begin
                    if (exp_op != OP_LOAD_DBUF || exp_wr_addr_q.size() == 0) begin
                        report_failure("unexpected data buffer write");
                    end else begin
                        beat_word = exp_wr_data_q.pop_front();
                        check_dbuf(exp_wr_addr_q.pop_front(), dbuf_wr_addr, beat_word,
                                   dbuf_wr_data, exp_en, dbuf_wr_en);
                    end
                end
                if (|idx_wr_en) begin
                    if (exp_op != OP_LOAD_IBUF || exp_wr_addr_q.size() == 0) begin
                        report_failure("unexpected index buffer write");
                    end else begin
                        beat_word = exp_wr_data_q.pop_front();
                        check_ibuf(exp_wr_addr_q.pop_front(), idx_wr_addr,
                                   beat_word[2*IDX_W-1:0], idx_wr_data,
                                   exp_en, idx_wr_en);
                    end
                end
                if (rx_done_pulse) begin
                    if (exp_done_id_q.size() == 0) begin
                        report_failure("unexpected done pulse");
                    end else begin
                        check_done(exp_done_id_q.pop_front(), rx_done_buf_id,
                                   exp_done_op_q.pop_front(), rx_done_opcode);
                        if (exp_wr_addr_q.size() != 0 || exp_addr_q.size() != 0)
                            report_failure("done pulse before the last write");
                        if (!(|dbuf_wr_en) && !(|idx_wr_en))
                            report_failure("done pulse without a write in the same cycle");
                    end
                end else if (exp_wr_addr_q.size() == 0 && exp_done_id_q.size() != 0) begin
                    report_failure("last write without a done pulse");
                end
            end
        end
    endtask

    task automatic run_instruction(input int idx);
        logic [INST_W-1:0] word;
        logic              is_load;
        int                errors_before;
        word          = ins_list[idx];
        test_name     = $sformatf("ins_%0d", idx);
        errors_before = errors;
        model_instruction(word, is_load);
        @(posedge clk);
        #DRIVE_DELAY;
        ins       = word;
        ins_valid = 1'b1;
        @(negedge clk);
        while (!ins_ready) @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        ins_valid = 1'b0;
        if (is_load) begin
            waiting_done = 1'b1;
            wait (exp_done_id_q.size() == 0);
            waiting_done = 1'b0;
        end else begin
            // dropped instruction spends a single cycle in the wait state
            @(negedge clk);
            @(negedge clk);
            if (!ins_ready) report_failure("ready did not return after a dropped instruction");
        end
        $display("%s op %0d bursts %0d %s", test_name, word[OP_LSB +: OP_W],
                 word[BURSTS_LSB +: BURSTS_W], (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        rst             = 1'b1;
        ins_valid       = 1'b0;
        ins             = '0;
        ddr1_data       = '0;
        ddr1_valid      = 1'b0;
        ddr1_addr_ready = 1'b0;
        build_instructions();
        fork
            drive_ddr();
            monitor_outputs();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        check_idle();
        for (int i = 0; i < NUM_INS; i++) begin
            run_instruction(i);
        end
        repeat (10) @(negedge clk);
        test_name = "drain";
        if (exp_addr_q.size() != 0 || exp_wr_addr_q.size() != 0 || exp_done_id_q.size() != 0)
            report_failure("expected addresses, writes or done pulses never came");
        $display("%0d instructions, %0d checks, %0d errors", NUM_INS, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
ddr2pe_pkg.sv
ins_decode.sv
ddr_addr_gen.sv
buf_writer.sv
ddr2pe.sv
tb_ddr2pe.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_ddr2pe
RTL_TOP    ?= ddr2pe
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   ?= TEST RESULT: PASS

RTL_FILES  ?= ddr2pe_pkg.sv ins_decode.sv ddr_addr_gen.sv buf_writer.sv ddr2pe.sv
SRC_FILES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRC_FILES) tb_checks.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
